// File: design/exc_pkg.sv
`default_nettype none

package exc_pkg;

    // one machine word
    typedef logic [31:0] word_t;

    // cause.exccode values that this core can raise
    typedef enum logic [4:0] {
        code_int  = 5'd0,
        code_adel = 5'd4,
        code_ades = 5'd5,
        code_sys  = 5'd8,
        code_bp   = 5'd9,
        code_ri   = 5'd10,
        code_ov   = 5'd12
    } exc_code_e;

    // per-instruction exception flags from the mem stage
    typedef struct packed {
        // fetch address error
        logic instr;
        logic ri;
        logic ov;
        logic sys;
        logic bp;
        // data address errors
        logic load;
        logic save;
    } exc_flags_t;

    // what the mem stage hands over each cycle
    typedef struct packed {
        exc_flags_t flags;
        word_t      pc;
        word_t      badvaddr;
        logic       in_delay_slot;
        logic       eret;
    } exc_req_t;

    // flush and redirect toward the pipeline
    typedef struct packed {
        logic      valid;
        exc_code_e code;
        logic      redirect;
        word_t     target;
    } exc_out_t;

    // record of a taken exception for cp0
    typedef struct packed {
        logic      valid;
        exc_code_e code;
        word_t     epc;
        logic      bd;
        logic      load_badv;
        word_t     badvaddr;
    } exc_commit_t;

    // status register, full word layout
    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  im;
        logic [4:0]  rsvd_lo;
        logic        erl;
        logic        exl;
        logic        ie;
    } cp0_status_t;

    // cause register, full word layout
    typedef struct packed {
        logic        bd;
        logic        ti;
        logic [13:0] rsvd_hi;
        logic [7:0]  ip;
        logic        rsvd_mid;
        exc_code_e   exc_code;
        logic [1:0]  rsvd_lo;
    } cp0_cause_t;

    // cp0 state seen by the exception unit
    typedef struct packed {
        cp0_status_t status;
        logic [7:0]  ip;
        word_t       epc;
    } cp0_view_t;

    // register numbers reachable over the bus
    typedef enum logic [4:0] {
        reg_badvaddr = 5'd8,
        reg_count    = 5'd9,
        reg_compare  = 5'd11,
        reg_status   = 5'd12,
        reg_cause    = 5'd13,
        reg_epc      = 5'd14
    } cp0_reg_e;

    // single-cycle register access strobe
    typedef struct packed {
        logic     strobe;
        logic     we;
        cp0_reg_e idx;
        word_t    wdata;
    } cp0_access_t;

    // wishbone classic master outputs
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [4:0] adr;
        word_t      dat;
    } wb_req_t;

    // single exception vector
    localparam word_t exc_entry = 32'hbfc00380;

    // epc backs up by one instruction for a delay slot
    localparam word_t bd_pc_offset = 32'd4;

    // cause.ip bit driven by count/compare
    localparam int ip_timer_bit = 7;

    // erl set out of reset, everything else clear
    localparam cp0_status_t status_reset = '{
        rsvd_hi: '0, im: '0, rsvd_lo: '0, erl: 1'b1, exl: 1'b0, ie: 1'b0
    };

endpackage

`default_nettype wire

// File: design/exc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exc_unit
    import exc_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        flush,
    input  wire logic [5:0]  ext_int,
    input  wire exc_req_t    req,
    input  wire cp0_view_t   cp0,
    output exc_out_t         out,
    output exc_commit_t      commit
);

    logic [7:0] pending;
    logic       int_en;
    logic       int_q;
    logic       exc_valid;
    exc_code_e  code;
    logic       addr_err;

    // hw lines sit at ip[7:2], sw and timer bits come from cause
    assign pending = ({ext_int, 2'b00} | cp0.ip) & cp0.status.im;

    // globally enabled and not already in exception or error level
    assign int_en = (|pending) & cp0.status.ie & ~cp0.status.exl & ~cp0.status.erl;

    // sampled interrupt, held until flushed or taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_q <= 1'b0;
        end else if (flush || exc_valid) begin
            int_q <= 1'b0;
        end else if (int_en) begin
            int_q <= 1'b1;
        end
    end

    assign exc_valid = int_q | (|req.flags);

    // fixed priority, interrupt first
    always_comb begin
        code     = code_int;
        addr_err = 1'b0;
        if (int_q) begin
            code = code_int;
        end else if (req.flags.instr) begin
            code     = code_adel;
            addr_err = 1'b1;
        end else if (req.flags.ri) begin
            code = code_ri;
        end else if (req.flags.ov) begin
            code = code_ov;
        end else if (req.flags.sys) begin
            code = code_sys;
        end else if (req.flags.bp) begin
            code = code_bp;
        end else if (req.flags.load) begin
            code     = code_adel;
            addr_err = 1'b1;
        end else if (req.flags.save) begin
            code     = code_ades;
            addr_err = 1'b1;
        end
    end

    // exception beats eret when both show up
    assign out.valid    = exc_valid;
    assign out.code     = code;
    assign out.redirect = exc_valid | req.eret;
    assign out.target   = exc_valid ? exc_entry : cp0.epc;

    // cp0 record, written on the edge closing this cycle
    assign commit.valid     = exc_valid;
    assign commit.code      = code;
    // branch address when the victim sits in a delay slot
    assign commit.epc       = req.in_delay_slot ? (req.pc - bd_pc_offset) : req.pc;
    assign commit.bd        = req.in_delay_slot;
    assign commit.load_badv = exc_valid & addr_err;
    assign commit.badvaddr  = req.badvaddr;

endmodule

`default_nettype wire

// File: design/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs
    import exc_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire exc_commit_t commit,
    input  wire logic        eret,
    input  wire cp0_access_t access,
    output word_t            rdata,
    output cp0_view_t        view
);

    cp0_status_t status;
    logic        cause_bd;
    exc_code_e   cause_code;
    logic [1:0]  cause_sw;
    logic        timer_int;
    word_t       epc;
    word_t       badvaddr;
    word_t       count;
    word_t       compare;

    cp0_status_t wr_status;
    cp0_cause_t  wr_cause;
    cp0_cause_t  cause;
    logic [7:0]  ip;
    logic        wr_en;

    // bus write data seen through the register layouts
    assign wr_status = cp0_status_t'(access.wdata);
    assign wr_cause  = cp0_cause_t'(access.wdata);
    assign wr_en     = access.strobe & access.we;

    // timer on ip7 and software bits on ip[1:0]
    always_comb begin
        ip               = '0;
        ip[1:0]          = cause_sw;
        ip[ip_timer_bit] = timer_int;
    end

    // status and cause control bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status     <= status_reset;
            cause_bd   <= 1'b0;
            cause_code <= code_int;
            cause_sw   <= 2'b00;
        end else begin
            // exception entry wins over eret and sw writes
            if (commit.valid) begin
                status.exl <= 1'b1;
            end else if (eret) begin
                status.exl <= 1'b0;
            end else if (wr_en && access.idx == reg_status) begin
                status.im  <= wr_status.im;
                status.erl <= wr_status.erl;
                status.exl <= wr_status.exl;
                status.ie  <= wr_status.ie;
            end
            if (commit.valid) begin
                cause_bd   <= commit.bd;
                cause_code <= commit.code;
            end
            // only the software ip bits are writable
            if (wr_en && access.idx == reg_cause) begin
                cause_sw <= wr_cause.ip[1:0];
            end
        end
    end

    // epc and badvaddr updates
    always_ff @(posedge clk) begin
        if (commit.valid) begin
            epc <= commit.epc;
        end else if (wr_en && access.idx == reg_epc) begin
            epc <= access.wdata;
        end
        // badvaddr is read-only from software
        if (commit.valid && commit.load_badv) begin
            badvaddr <= commit.badvaddr;
        end
    end

    // count/compare timer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count     <= '0;
            // far away so the timer stays quiet out of reset
            compare   <= '1;
            timer_int <= 1'b0;
        end else begin
            if (wr_en && access.idx == reg_count) begin
                count <= access.wdata;
            end else begin
                count <= count + 32'd1;
            end
            // compare write acks the timer
            if (wr_en && access.idx == reg_compare) begin
                compare   <= access.wdata;
                timer_int <= 1'b0;
            end else if (count == compare) begin
                timer_int <= 1'b1;
            end
        end
    end

    always_comb begin
        cause          = '0;
        cause.bd       = cause_bd;
        cause.ti       = timer_int;
        cause.ip       = ip;
        cause.exc_code = cause_code;
    end

    // unknown index reads as zero
    always_comb begin
        case (access.idx)
            reg_badvaddr: rdata = badvaddr;
            reg_count:    rdata = count;
            reg_compare:  rdata = compare;
            reg_status:   rdata = status;
            reg_cause:    rdata = cause;
            reg_epc:      rdata = epc;
            default:      rdata = '0;
        endcase
    end

    assign view.status = status;
    assign view.ip     = ip;
    assign view.epc    = epc;

endmodule

`default_nettype wire

// File: design/cp0_wb_slave.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_wb_slave
    import exc_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire wb_req_t     wb,
    input  wire word_t       rdata,
    output cp0_access_t      access,
    output word_t            dat_r,
    output logic             ack
);

    logic     ack_q;
    logic     we_q;
    cp0_reg_e idx_q;
    word_t    wdata_q;
    logic     req_seen;

    // new request, not the tail of the one being acked
    assign req_seen = wb.cyc & wb.stb & ~ack_q;

    // one-cycle ack after the request is sampled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_seen;
        end
    end

    // captured request fields
    always_ff @(posedge clk) begin
        if (req_seen) begin
            we_q    <= wb.we;
            // raw address, out-of-range values fall to the default read
            idx_q   <= cp0_reg_e'(wb.adr);
            wdata_q <= wb.dat;
        end
    end

    // register strobe lines up with ack
    assign access.strobe = ack_q;
    assign access.we     = we_q;
    assign access.idx    = idx_q;
    assign access.wdata  = wdata_q;

    // read data only driven while acking
    assign dat_r = ack_q ? rdata : '0;
    assign ack   = ack_q;

endmodule

`default_nettype wire

// File: design/exc_top.sv
`timescale 1ns/1ps
`default_nettype none

module exc_top
    import exc_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       flush,
    input  wire logic [5:0] ext_int,
    input  wire exc_req_t   exc_req,
    input  wire wb_req_t    wb_req,
    output exc_out_t        exc_out,
    output word_t           wb_dat_r,
    output logic            wb_ack
);

    cp0_view_t   cp0_view;
    exc_commit_t exc_commit;
    cp0_access_t cp0_access;
    word_t       rdata;

    // cause select, redirect and commit record
    exc_unit u_exc_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .ext_int (ext_int),
        .req     (exc_req),
        .cp0     (cp0_view),
        .out     (exc_out),
        .commit  (exc_commit)
    );

    // cp0 state, eret taken straight from the mem stage
    cp0_regs u_cp0_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .commit (exc_commit),
        .eret   (exc_req.eret),
        .access (cp0_access),
        .rdata  (rdata),
        .view   (cp0_view)
    );

    // mfc0/mtc0 path
    cp0_wb_slave u_cp0_wb_slave (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb     (wb_req),
        .rdata  (rdata),
        .access (cp0_access),
        .dat_r  (wb_dat_r),
        .ack    (wb_ack)
    );

endmodule

`default_nettype wire

// File: testbench/exc_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module exc_asserts
    import exc_pkg::*;
(
    input wire logic        clk,
    input wire logic        rst_n,
    input wire exc_out_t    exc_out,
    input wire logic        wb_ack,
    input wire word_t       wb_dat_r,
    input wire cp0_access_t cp0_access
);

    // bumped by every failing assertion
    int unsigned fail_count = 0;
    word_t       epc_rd;

    // epc value the bus master fetched most recently
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            epc_rd <= '0;
        end else if (wb_ack && !cp0_access.we && cp0_access.idx == reg_epc) begin
            epc_rd <= wb_dat_r;
        end
    end

    // quiet handshake and pipeline controls right out of reset
    reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !wb_ack && !cp0_access.strobe && !exc_out.valid && !exc_out.redirect)
        else begin
            $error("ack, strobe or redirect high right after reset");
            fail_count++;
        end

    // ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin
            $error("wishbone ack held for two cycles");
            fail_count++;
        end

    // a taken exception always vectors to the single entry
    entry_on_exc: assert property (@(posedge clk) disable iff (!rst_n)
        exc_out.valid |-> exc_out.target == exc_entry)
        else begin
            $error("exception redirect target is not the exception entry");
            fail_count++;
        end

    // eret goes back to the epc software saw
    eret_to_epc: assert property (@(posedge clk) disable iff (!rst_n)
        exc_out.redirect && !exc_out.valid |-> exc_out.target == epc_rd)
        else begin
            $error("eret redirect target differs from the epc last read");
            fail_count++;
        end

endmodule

bind exc_top exc_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .exc_out    (exc_out),
    .wb_ack     (wb_ack),
    .wb_dat_r   (wb_dat_r),
    .cp0_access (cp0_access)
);

`default_nettype wire

// File: testbench/exc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exc_tb
    import exc_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       flush;
    logic [5:0] ext_int;
    exc_req_t   exc_req;
    wb_req_t    wb_req;
    exc_out_t   exc_out;
    word_t      wb_dat_r;
    logic       wb_ack;
    integer     seed;

    exc_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .ext_int  (ext_int),
        .exc_req  (exc_req),
        .wb_req   (wb_req),
        .exc_out  (exc_out),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // one classic cycle held until ack and dropped on the ack cycle
    task automatic wb_cycle(input logic write_en, input logic [4:0] addr, input word_t data,
                            output word_t rd);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: write_en, adr: addr, dat: data};
        @(negedge clk);
        while (!wb_ack) begin
            waited++;
            if (waited > 16) begin
                fail_run("no wishbone ack within 16 cycles");
            end
            @(negedge clk);
        end
        // read data only valid while ack is up
        rd     = wb_dat_r;
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [4:0] addr, input word_t data);
        word_t ignored;
        wb_cycle(1'b1, addr, data, ignored);
    endtask

    task automatic wb_read(input logic [4:0] addr, output word_t data);
        wb_cycle(1'b0, addr, '0, data);
    endtask

    // polls at falling edges until the pipeline is flushed
    task automatic wait_exception(input string what, input int limit);
        int waited;
        waited = 0;
        while (!exc_out.valid) begin
            waited++;
            if (waited > limit) begin
                fail_run(what);
            end
            @(negedge clk);
        end
    endtask

    // gated interrupt must not show up over the window
    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check(name, 32'd0, 32'(exc_out.valid));
        end
    endtask

    // fetch, ri, ov, sys, bp, load and save in falling priority
    function automatic exc_code_e code_for(input exc_flags_t f);
        if (f.instr) begin
            return code_adel;
        end else if (f.ri) begin
            return code_ri;
        end else if (f.ov) begin
            return code_ov;
        end else if (f.sys) begin
            return code_sys;
        end else if (f.bp) begin
            return code_bp;
        end else if (f.load) begin
            return code_adel;
        end else begin
            return code_ades;
        end
    endfunction

    function automatic logic is_addr_err(input exc_flags_t f);
        exc_code_e c;
        c = code_for(f);
        return (c == code_adel) || (c == code_ades);
    endfunction

    initial begin
        word_t       rd;
        word_t       r;
        word_t       old_bv;
        word_t       exp_epc;
        logic [6:0]  top;
        int          p;
        exc_code_e   exp_code;
        exc_req_t    held;
        cp0_cause_t  cause;
        cp0_status_t status;
        seed    = 32'hfb083d1c;
        clk     = 1'b0;
        rst_n   = 1'b0;
        flush   = 1'b0;
        ext_int = '0;
        exc_req = '0;
        wb_req  = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // erl stays set through plain register access so nothing interrupts
        wb_write(reg_status, 32'h0000_c306);
        wb_read(reg_status, rd);
        check("status readback", 32'h0000_c306, rd);
        wb_write(reg_epc, 32'h8000_1234);
        wb_read(reg_epc, rd);
        check("epc readback", 32'h8000_1234, rd);
        wb_write(reg_compare, 32'h7fff_0000);
        wb_read(reg_compare, rd);
        check("compare readback", 32'h7fff_0000, rd);
        wb_write(5'd3, 32'hdead_beef);
        wb_read(5'd3, rd);
        check("unknown index", 32'd0, rd);

        // one random exception at a time for priority and the cp0 record
        for (int i = 0; i < 40; i++) begin
            // exl clear and erl set so each entry has to raise exl again
            wb_write(reg_status, 32'h0000_0004);
            wb_read(reg_badvaddr, old_bv);
            r   = $random(seed);
            p   = r % 7;
            // highest set flag at p with random flags below it
            top = 7'd1 << p;
            r   = $random(seed);
            @(negedge clk);
            exc_req                = '0;
            exc_req.flags          = exc_flags_t'(top | (r[6:0] & (top - 7'd1)));
            exc_req.in_delay_slot  = r[7];
            r                      = $random(seed);
            exc_req.pc             = {r[31:2], 2'b00};
            exc_req.badvaddr       = $random(seed);
            held                   = exc_req;
            exp_code               = code_for(held.flags);
            exp_epc = held.in_delay_slot ? (held.pc - 32'd4) : held.pc;
            #10;
            check("priority valid", 32'd1, 32'(exc_out.valid));
            check("priority code", 32'(exp_code), 32'(exc_out.code));
            @(negedge clk);
            exc_req = '0;
            wb_read(reg_epc, rd);
            check("record epc", exp_epc, rd);
            wb_read(reg_cause, rd);
            cause = cp0_cause_t'(rd);
            check("record exccode", 32'(exp_code), 32'(cause.exc_code));
            check("record bd", 32'(held.in_delay_slot), 32'(cause.bd));
            wb_read(reg_status, rd);
            status = cp0_status_t'(rd);
            check("record exl", 32'd1, 32'(status.exl));
            wb_read(reg_badvaddr, rd);
            check("record badvaddr", is_addr_err(held.flags) ? held.badvaddr : old_bv, rd);
        end
        @(negedge clk);
        #10;
        check("no flags valid", 32'd0, 32'(exc_out.valid));

        // eret back to the epc of the last exception
        @(negedge clk);
        exc_req.eret = 1'b1;
        #10;
        check("eret redirect", 32'd1, 32'(exc_out.redirect));
        check("eret valid", 32'd0, 32'(exc_out.valid));
        check("eret target", exp_epc, exc_out.target);
        @(negedge clk);
        exc_req = '0;
        wb_read(reg_status, rd);
        status = cp0_status_t'(rd);
        check("eret exl", 32'd0, 32'(status.exl));

        // ext_int[0] lands on ip2 and is gated by im, ie, exl and erl in turn
        wb_write(reg_status, 32'h0000_0001);
        @(negedge clk);
        ext_int = 6'b000001;
        expect_quiet("int gated by im", 12);
        wb_write(reg_status, 32'h0000_0400);
        expect_quiet("int gated by ie", 12);
        wb_write(reg_status, 32'h0000_0403);
        expect_quiet("int gated by exl", 12);
        wb_write(reg_status, 32'h0000_0405);
        expect_quiet("int gated by erl", 12);
        wb_write(reg_status, 32'h0000_0401);
        wait_exception("no external interrupt within 20 cycles", 20);
        check("ext int code", 32'(code_int), 32'(exc_out.code));
        @(negedge clk);
        ext_int = '0;

        // count/compare on ip7
        wb_read(reg_count, rd);
        wb_write(reg_compare, rd + 32'd24);
        wb_write(reg_status, 32'h0000_8001);
        wait_exception("no timer interrupt within 60 cycles", 60);
        check("timer code", 32'(code_int), 32'(exc_out.code));
        wb_read(reg_cause, rd);
        cause = cp0_cause_t'(rd);
        check("timer ip7 set", 32'd1, 32'(cause.ip[ip_timer_bit]));
        wb_write(reg_compare, 32'h7fff_0000);
        wb_read(reg_cause, rd);
        cause = cp0_cause_t'(rd);
        check("timer ip7 cleared", 32'd0, 32'(cause.ip[ip_timer_bit]));

        if (dut.u_asserts.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("%0d bound assertions failed", dut.u_asserts.fail_count);
            $display("Simulation failed");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

`default_nettype wire

// File: sim.f
design/exc_pkg.sv
design/exc_unit.sv
design/cp0_regs.sv
design/cp0_wb_slave.sv
design/exc_top.sv
testbench/exc_asserts.sv
testbench/exc_tb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module exc_tb -o exc_sim

status=0
./obj_dir/exc_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
